/* bench/board_ctrl_assert.sv */
// protocol assertions, bound into the reply sender and the i2c sequencer; unused inputs are tied low
`timescale 1ns/100ps

module board_ctrl_assert (
	input logic clk,
	input logic rst_n,
	input logic tx_start,
	input logic tx_busy,
	input logic i2c_rw
);

	a_start_idle: assert property (@(posedge clk) disable iff (!rst_n) tx_start |-> !tx_busy)
		else $error("tx_start issued while the transmitter is busy");

	a_start_pulse: assert property (@(posedge clk) disable iff (!rst_n) tx_start |=> !tx_start)
		else $error("tx_start held longer than one cycle");

	a_write_only: assert property (@(posedge clk) disable iff (!rst_n) !i2c_rw)
		else $error("i2c read requested, only writes exist");

endmodule

bind reply_sender board_ctrl_assert a_tx (
	.clk, .rst_n, .tx_start, .tx_busy, .i2c_rw(1'b0)
);

bind i2c_sequencer board_ctrl_assert a_i2c (
	.clk, .rst_n, .tx_start(1'b0), .tx_busy(1'b0), .i2c_rw
);

/* bench/board_ctrl_check.sv */
// scoreboard of the board controller; collects one test's traffic and compares it when check_now pulses
`timescale 1ns/100ps

module board_ctrl_check (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  new_com_data,
	input  scope_pkg::byte_t      com_data,
	input  logic                  tx_start,
	input  scope_pkg::byte_t      tx_data,
	input  logic                  i2c_ena,
	input  logic                  i2c_busy,
	input  scope_pkg::i2c_addr_t  i2c_addr,
	input  scope_pkg::byte_t      i2c_datawr,
	input  logic                  serial_passthrough,
	input  logic [1:0]            master_clock,
	input  logic                  imthefirst,
	input  logic                  imthelast,
	input  scope_pkg::trig_cfg_t  trig_cfg,
	input  scope_pkg::chan_mask_t gain_sel,
	input  scope_pkg::chan_mask_t oversamp,
	input  scope_pkg::board_id_t  board_id,
	input  logic                  check_now,
	input  logic                  run_done,
	input  logic [95:0]           test_name,
	input  logic [47:0]           exp_fwd,  // byte 0 in the low bits
	input  int                    n_fwd,
	input  logic [63:0]           exp_tx,
	input  int                    n_tx,
	input  scope_pkg::i2c_req_t   exp_i2c0,
	input  scope_pkg::i2c_req_t   exp_i2c1,
	input  int                    n_i2c,
	input  logic [41:0]           exp_lvl,
	output int                    err_count
);
	import scope_pkg::*;

	byte_t       fwd_q [$];  // forwarded chain bytes
	byte_t       tx_q [$];   // reply bytes
	logic [14:0] pair_q [$]; // {addr, byte} per started i2c byte
	int          starts;     // rising edges of i2c_ena
	int          checks;
	logic        ena_d;

	initial begin
		err_count = 0;
		checks    = 0;
		starts    = 0;
		ena_d     = 1'b0;
	end

	task automatic compare_val(input string what, input logic [63:0] exp, input logic [63:0] act);
		checks++;
		if (exp !== act) begin
			err_count++;
			$display("mismatch %0s %0s: expected %h actual %h", test_name, what, exp, act);
		end
	endtask

	task automatic compare_row;
		logic [14:0] exp_pairs [$];
		i2c_req_t    reqs [2];
		byte_t       d;
		reqs[0] = exp_i2c0;
		reqs[1] = exp_i2c1;
		// expand the expected writes into the byte stream the master should see
		for (int t = 0; t < n_i2c; t++) begin
			for (int j = 0; j < reqs[t].count; j++) begin
				d = (j == 0) ? reqs[t].data0 : (j == 1) ? reqs[t].data1 : reqs[t].data2;
				exp_pairs.push_back({reqs[t].addr, d});
			end
		end
		compare_val("forwarded count", n_fwd, fwd_q.size());
		for (int i = 0; i < n_fwd && i < fwd_q.size(); i++)
			compare_val("forwarded byte", exp_fwd[8*i +: 8], fwd_q[i]);
		compare_val("reply count", n_tx, tx_q.size());
		for (int i = 0; i < n_tx && i < tx_q.size(); i++)
			compare_val("reply byte", exp_tx[8*i +: 8], tx_q[i]);
		compare_val("i2c transactions", n_i2c, starts); // one ena rise per write
		compare_val("i2c byte count", exp_pairs.size(), pair_q.size());
		for (int i = 0; i < exp_pairs.size() && i < pair_q.size(); i++)
			compare_val("i2c addr and byte", exp_pairs[i], pair_q[i]);
		compare_val("levels", exp_lvl, {serial_passthrough, master_clock, imthefirst, imthelast,
			trig_cfg, gain_sel, oversamp, board_id});
		fwd_q.delete();
		tx_q.delete();
		pair_q.delete();
		starts = 0;
	endtask

	always @(posedge clk) begin
		if (rst_n) begin
			if (new_com_data) fwd_q.push_back(com_data);
			if (tx_start) tx_q.push_back(tx_data);
			if (i2c_ena && !i2c_busy) pair_q.push_back({i2c_addr, i2c_datawr}); // master starts a byte
			if (i2c_ena && !ena_d) starts++;
			ena_d = i2c_ena;
			if (check_now) compare_row();
			if (run_done) $display("checks run %0d, errors %0d", checks, err_count);
		end
	end

endmodule

/* bench/board_ctrl_tb.sv */
// board controller testbench; rows run in order and share state, each byte waits out any reply it starts
`timescale 1ns/100ps

module board_ctrl_tb;
	import scope_pkg::*;

	typedef struct packed {
		logic [95:0] name;
		logic [47:0] ins;   // command bytes, byte 0 in the low bits
		int          n_in;
		logic [47:0] fwd;   // expected chain bytes
		int          n_fwd;
		int          txk;   // 0 no reply, 1 chip id, 2 delay then carry
		i2c_req_t    i2c0;
		i2c_req_t    i2c1;
		int          n_i2c;
		logic [41:0] lvl;   // {passthrough, mclk, first, last, trig, gain, ovs, id}
	} row_t;

	localparam int N_ROWS = 17;

	logic        clk, rst_n, rx_ready, tx_busy, tx_start, new_com_data, i2c_busy, i2c_ena, i2c_rw;
	byte_t       rx_data, tx_data, com_data, i2c_datawr, delay_count, carry_count;
	logic [63:0] chip_id, exp_tx;
	logic [1:0]  master_clock;
	logic        serial_passthrough, imthefirst, imthelast, check_now, run_done, table_ready;
	trig_cfg_t   trig_cfg;
	chan_mask_t  gain_sel, oversamp;
	board_id_t   board_id;
	i2c_addr_t   i2c_addr;
	row_t        rows [N_ROWS];
	row_t        cur;
	int          n_tx, err_count, total_bytes, tx_cnt, i2c_cnt;
	logic [31:0] seed;

	tb_clock i_clock (.clk, .rst_n);

	board_ctrl i_board_ctrl (.*);

	board_ctrl_check i_check (
		.clk, .rst_n, .new_com_data, .com_data, .tx_start, .tx_data, .i2c_ena, .i2c_busy,
		.i2c_addr, .i2c_datawr, .serial_passthrough, .master_clock, .imthefirst, .imthelast,
		.trig_cfg, .gain_sel, .oversamp, .board_id, .check_now, .run_done,
		.test_name(cur.name), .exp_fwd(cur.fwd), .n_fwd(cur.n_fwd), .exp_tx, .n_tx,
		.exp_i2c0(cur.i2c0), .exp_i2c1(cur.i2c1), .n_i2c(cur.n_i2c), .exp_lvl(cur.lvl),
		.err_count
	);

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	function automatic i2c_req_t wr(input i2c_addr_t a, input byte_t d0, d1, d2);
		return '{addr: a, count: 2'd2, data0: d0, data1: d1, data2: d2}; // two byte writes
	endfunction

	function automatic logic [41:0] lv(input logic pt, input logic [1:0] mc, input logic f, l,
		input byte_t th, th2, input logic [3:0] ty, input logic ro, input chan_mask_t g, o,
		input board_id_t id);
		return {pt, mc, f, l, th, th2, ty, ro, g, o, id};
	endfunction

	task automatic add_row(input int k, input logic [95:0] name, input logic [47:0] ins,
		input int n_in, input logic [47:0] fwd, input int n_fwd, input int txk,
		input i2c_req_t q0, q1, input int n_i2c, input logic [41:0] lvl);
		rows[k] = '{name: name, ins: ins, n_in: n_in, fwd: fwd, n_fwd: n_fwd, txk: txk,
			i2c0: q0, i2c1: q1, n_i2c: n_i2c, lvl: lvl};
		total_bytes += n_in;
	endtask

	// one byte, then wait until the serial side has been quiet for 8 cycles
	task automatic send_byte(input byte_t b);
		int idle;
		@(posedge clk);
		#1 rx_ready = 1'b1;
		rx_data = b;
		@(posedge clk);
		#1 rx_ready = 1'b0;
		idle = 0;
		// a reply starts within 4 cycles, gaps inside a reply stay below 3
		while (idle < 8) begin
			@(posedge clk);
			if (tx_start || tx_busy) idle = 0;
			else idle++;
		end
	endtask

	// all chain, serial and i2c activity has stopped for 10 cycles
	task automatic wait_quiet;
		int quiet;
		quiet = 0;
		while (quiet < 10) begin
			@(posedge clk);
			if (tx_start || tx_busy || i2c_ena || i2c_busy || new_com_data) quiet = 0;
			else quiet++;
		end
	endtask

	// serial transmitter model, busy for 3 cycles from the cycle after tx_start
	always @(posedge clk) begin
		logic s;
		s = tx_start;
		#1;
		if (s) begin
			tx_busy = 1'b1;
			tx_cnt  = 3;
		end else if (tx_busy) begin
			tx_cnt--;
			if (tx_cnt == 0) tx_busy = 1'b0;
		end
	end

	// i2c master model, takes a byte when enabled and idle, then busy 6 cycles
	always @(posedge clk) begin
		logic e, b;
		e = i2c_ena;
		b = i2c_busy;
		#1;
		if (e && !b) begin
			i2c_busy = 1'b1;
			i2c_cnt  = 6;
		end else if (b) begin
			i2c_cnt--;
			if (i2c_cnt == 0) i2c_busy = 1'b0;
		end
	end

	initial begin
		wait (table_ready);
		repeat (total_bytes * 200 + 2000) @(posedge clk);
		$display("timeout: tests did not finish within %0d cycles", total_bytes * 200 + 2000);
		$display("SOME TESTS FAILED");
		$finish;
	end

	initial begin
		table_ready = 1'b0;
		rx_ready    = 1'b0;
		rx_data     = 8'h00;
		tx_busy     = 1'b0;
		i2c_busy    = 1'b0;
		check_now   = 1'b0;
		run_done    = 1'b0;
		total_bytes = 0;
		seed        = 32'd68090;
		seed           = lcg_next(seed);
		chip_id[31:0]  = seed;
		seed           = lcg_next(seed);
		chip_id[63:32] = seed;
		seed           = lcg_next(seed);
		delay_count    = seed[23:16];
		seed           = lcg_next(seed);
		carry_count    = seed[23:16];
		add_row(0, "id0", 48'h00, 1, 48'h01, 1, 0, wr(7'h21, 8'h12, 8'hF0, 8'h00), '0, 1,
			lv(0, 2'b00, 1, 0, 8'h80, 8'hFF, 4'h1, 1, 4'h0, 4'h3, 8'd0));
		add_row(1, "id3", 48'h03, 1, 48'h04, 1, 0, wr(7'h21, 8'h12, 8'hF3, 8'h00), '0, 1,
			lv(0, 2'b01, 0, 0, 8'h80, 8'hFF, 4'h1, 1, 4'h0, 4'h3, 8'd3));
		add_row(2, "act_other", 48'h1F, 1, 48'h1F, 1, 0, '0, '0, 0,
			lv(1, 2'b01, 0, 0, 8'h80, 8'hFF, 4'h1, 1, 4'h0, 4'h3, 8'd3));
		add_row(3, "pass_reply", 48'h848E, 2, 48'h848E, 2, 0, '0, '0, 0,
			lv(1, 2'b01, 0, 0, 8'h80, 8'hFF, 4'h1, 1, 4'h0, 4'h3, 8'd3));
		add_row(4, "act_self", 48'h21, 1, 48'h0, 0, 0, '0, '0, 0,
			lv(0, 2'b01, 0, 0, 8'h80, 8'hFF, 4'h1, 1, 4'h0, 4'h3, 8'd3));
		add_row(5, "chipid", 48'h8E, 1, 48'h0, 0, 1, '0, '0, 0,
			lv(0, 2'b01, 0, 0, 8'h80, 8'hFF, 4'h1, 1, 4'h0, 4'h3, 8'd3));
		add_row(6, "tdc", 48'h8584, 2, 48'h0, 0, 2, '0, '0, 0,
			lv(0, 2'b01, 0, 0, 8'h80, 8'hFF, 4'h1, 1, 4'h0, 4'h3, 8'd3));
		add_row(7, "trig", 48'h0680C08C407F, 6, 48'h0680C08C407F, 6, 0, '0, '0, 0,
			lv(0, 2'b01, 0, 0, 8'h40, 8'hC0, 4'h6, 1, 4'h0, 4'h3, 8'd3));
		// off first, so only a working on leaves rolling set
		add_row(8, "roll", 48'h6566, 2, 48'h6566, 2, 0, '0, '0, 0,
			lv(0, 2'b01, 0, 0, 8'h40, 8'hC0, 4'h6, 1, 4'h0, 4'h3, 8'd3));
		add_row(9, "roll_off", 48'h66, 1, 48'h66, 1, 0, '0, '0, 0,
			lv(0, 2'b01, 0, 0, 8'h40, 8'hC0, 4'h6, 0, 4'h0, 4'h3, 8'd3));
		add_row(10, "gain", 48'h0D86, 2, 48'h0D86, 2, 0, wr(7'h20, 8'h12, 8'h32, 8'h00), '0, 1,
			lv(0, 2'b01, 0, 0, 8'h40, 8'hC0, 4'h6, 0, 4'h2, 4'h3, 8'd3));
		add_row(11, "ovs_other", 48'h028D, 2, 48'h028D, 2, 0, wr(7'h20, 8'h12, 8'h32, 8'h00), '0,
			1, lv(0, 2'b01, 0, 0, 8'h40, 8'hC0, 4'h6, 0, 4'h2, 4'h3, 8'd3));
		add_row(12, "ovs", 48'h0C8D, 2, 48'h0C8D, 2, 0, wr(7'h20, 8'h12, 8'h22, 8'h00), '0, 1,
			lv(0, 2'b01, 0, 0, 8'h40, 8'hC0, 4'h6, 0, 4'h2, 4'h2, 8'd3));
		add_row(13, "raw", 48'hCCBBAA500288, 6, 48'hCCBBAA500288, 6, 0,
			wr(7'h50, 8'hAA, 8'hBB, 8'hCC), '0, 1,
			lv(0, 2'b01, 0, 0, 8'h40, 8'hC0, 4'h6, 0, 4'h2, 4'h2, 8'd3));
		add_row(14, "last", 48'h17, 1, 48'h17, 1, 0, wr(7'h21, 8'h12, 8'hFF, 8'h00), '0, 1,
			lv(0, 2'b01, 0, 1, 8'h40, 8'hC0, 4'h6, 0, 4'h2, 4'h2, 8'd3));
		add_row(15, "not_last", 48'h14, 1, 48'h14, 1, 0, wr(7'h21, 8'h12, 8'hF3, 8'h00), '0, 1,
			lv(0, 2'b01, 0, 0, 8'h40, 8'hC0, 4'h6, 0, 4'h2, 4'h2, 8'd3));
		// id change and gain command back to back, led write first
		add_row(16, "shared", 48'h048601, 3, 48'h048602, 3, 0, wr(7'h21, 8'h12, 8'hF1, 8'h00),
			wr(7'h20, 8'h12, 8'h23, 8'h00), 2,
			lv(0, 2'b01, 0, 0, 8'h40, 8'hC0, 4'h6, 0, 4'h3, 4'h2, 8'd1));
		cur = rows[0];
		table_ready = 1'b1;
		wait (rst_n);
		wait_quiet();
		for (int k = 0; k < N_ROWS; k++) begin
			cur    = rows[k];
			exp_tx = (cur.txk == 1) ? chip_id : {48'd0, carry_count, delay_count};
			n_tx   = (cur.txk == 1) ? 8 : (cur.txk == 2) ? 2 : 0;
			for (int b = 0; b < cur.n_in; b++) send_byte(cur.ins[8*b +: 8]);
			wait_quiet();
			@(posedge clk);
			#1 check_now = 1'b1;
			@(posedge clk);
			#1 check_now = 1'b0;
		end
		@(posedge clk);
		#1 run_done = 1'b1;
		@(posedge clk);
		#1 run_done = 1'b0;
		if (err_count == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

/* bench/tb_clock.sv */
// testbench clock and reset source; 10 ns period, reset held low for the first 8 rising edges
`timescale 1ns/100ps

module tb_clock (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk; // 100 MHz
	end

	initial begin
		rst_n = 1'b0;
		repeat (8) @(posedge clk);
		#1 rst_n = 1'b1; // released just after the 8th edge
	end

endmodule

/* board_ctrl.f */
design/scope_pkg.sv
design/cmd_decoder.sv
design/reply_sender.sv
design/id_indicator.sv
design/i2c_arbiter.sv
design/i2c_sequencer.sv
design/board_ctrl.sv
bench/tb_clock.sv
bench/board_ctrl_check.sv
bench/board_ctrl_assert.sv
bench/board_ctrl_tb.sv

/* design/board_ctrl.sv */
// top of the board command processor; the serial receiver, transmitter and i2c master sit outside
`timescale 1ns/100ps

module board_ctrl (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  rx_ready,
	input  scope_pkg::byte_t      rx_data,
	input  logic                  tx_busy,
	output logic                  tx_start,
	output scope_pkg::byte_t      tx_data,
	output scope_pkg::byte_t      com_data,
	output logic                  new_com_data,
	input  logic [63:0]           chip_id,
	input  scope_pkg::byte_t      delay_count,
	input  scope_pkg::byte_t      carry_count,
	output logic                  serial_passthrough,
	output logic [1:0]            master_clock,
	output logic                  imthefirst,
	output logic                  imthelast,
	output scope_pkg::trig_cfg_t  trig_cfg,
	output scope_pkg::chan_mask_t gain_sel,
	output scope_pkg::chan_mask_t oversamp,
	output scope_pkg::board_id_t  board_id,
	output logic                  i2c_ena,
	output scope_pkg::i2c_addr_t  i2c_addr,
	output logic                  i2c_rw,
	output scope_pkg::byte_t      i2c_datawr,
	input  logic                  i2c_busy
);
	import scope_pkg::*;

	reply_t   reply;
	logic     reply_go, reply_done;
	i2c_req_t cmd_req, led_req, seq_req;
	logic     cmd_valid, cmd_gnt, led_valid, led_gnt; // two requesters of the bus
	logic     seq_go, seq_done;

	cmd_decoder i_cmd_decoder (
		.clk, .rst_n, .rx_ready, .rx_data, .chip_id, .delay_count, .carry_count,
		.reply_done, .i2c_gnt(cmd_gnt), .com_data, .new_com_data, .serial_passthrough,
		.master_clock, .imthefirst, .imthelast, .trig_cfg, .gain_sel, .oversamp,
		.reply_go, .reply, .i2c_req_valid(cmd_valid), .i2c_req(cmd_req), .board_id
	);

	reply_sender i_reply_sender (
		.clk, .rst_n, .reply_go, .reply, .tx_busy, .tx_start, .tx_data, .reply_done
	);

	id_indicator i_id_indicator (
		.clk, .rst_n, .board_id, .last_board(imthelast), .gnt(led_gnt),
		.req_valid(led_valid), .req(led_req)
	);

	i2c_arbiter i_i2c_arbiter (
		.clk, .rst_n, .cmd_valid, .cmd_req, .led_valid, .led_req, .seq_done,
		.cmd_gnt, .led_gnt, .seq_go, .seq_req
	);

	i2c_sequencer i_i2c_sequencer (
		.clk, .rst_n, .seq_go, .seq_req, .i2c_busy, .i2c_ena, .i2c_addr, .i2c_rw,
		.i2c_datawr, .seq_done
	);

endmodule

/* design/cmd_decoder.sv */
// command decoder of one chain board; bytes that arrive while a reply or an i2c grant is pending are dropped
`timescale 1ns/100ps

module cmd_decoder (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  rx_ready,
	input  scope_pkg::byte_t      rx_data,
	input  logic [63:0]           chip_id,
	input  scope_pkg::byte_t      delay_count,
	input  scope_pkg::byte_t      carry_count,
	input  logic                  reply_done,
	input  logic                  i2c_gnt,
	output scope_pkg::byte_t      com_data,
	output logic                  new_com_data,
	output logic                  serial_passthrough,
	output logic [1:0]            master_clock,
	output logic                  imthefirst,
	output logic                  imthelast,
	output scope_pkg::trig_cfg_t  trig_cfg,
	output scope_pkg::chan_mask_t gain_sel,
	output scope_pkg::chan_mask_t oversamp,
	output logic                  reply_go,
	output scope_pkg::reply_t     reply,
	output logic                  i2c_req_valid,
	output scope_pkg::i2c_req_t   i2c_req,
	output scope_pkg::board_id_t  board_id
);
	import scope_pkg::*;

	dec_state_e state;
	byte_t      cmd;          // command byte under decode
	byte_t      arg_buf [5];  // argument bytes, in arrival order
	logic [2:0] arg_cnt;      // arguments collected so far
	logic [2:0] arg_need;     // arguments the command takes
	logic       own_ch;       // channel argument belongs to this board
	chan_mask_t ch_bit;
	chan_mask_t gain_nxt;
	chan_mask_t ovs_nxt;

	assign imthefirst = (board_id == 8'd0);

	always_comb begin
		case (cmd)
			CMD_THRESH, CMD_THRESH2, CMD_TYPE, CMD_GAIN, CMD_OVERSAMP: arg_need = 3'd1;
			CMD_I2C_RAW: arg_need = 3'd5; // count, address, three data bytes
			default: arg_need = 3'd0;
		endcase
	end

	// channel n lives on board n/4, as bit n%4
	assign own_ch   = ({2'b00, arg_buf[0][7:2]} == board_id);
	assign ch_bit   = 4'b0001 << arg_buf[0][1:0];
	assign gain_nxt = own_ch ? (gain_sel ^ ch_bit) : gain_sel;
	assign ovs_nxt  = own_ch ? (oversamp ^ ch_bit) : oversamp;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state              <= DEC_IDLE;
			arg_cnt            <= 3'd0;
			new_com_data       <= 1'b0;
			reply_go           <= 1'b0;
			i2c_req_valid      <= 1'b0;
			serial_passthrough <= 1'b0;
			master_clock       <= 2'b00; // own clock master until told otherwise
			imthelast          <= 1'b0;
			board_id           <= BOARD_ID_RESET;
			trig_cfg           <= TRIG_RESET;
			gain_sel           <= GAIN_RESET;
			oversamp           <= OVERSAMP_RESET;
		end else begin
			new_com_data <= 1'b0; // one cycle strobes
			reply_go     <= 1'b0;
			case (state)
				DEC_IDLE: begin
					if (rx_ready) begin
						cmd     <= rx_data;
						arg_cnt <= 3'd0;
						state   <= DEC_SOLVE;
					end
				end
				DEC_MORE: begin
					if (rx_ready) begin
						arg_buf[arg_cnt] <= rx_data;
						com_data         <= rx_data; // arguments go down the chain as they come
						new_com_data     <= 1'b1;
						arg_cnt          <= arg_cnt + 3'd1;
						if (arg_cnt + 3'd1 == arg_need) state <= DEC_SOLVE;
					end
				end
				DEC_SOLVE: begin
					state <= DEC_IDLE;
					if (cmd <= CMD_ID_LAST) begin
						board_id     <= cmd;
						master_clock <= (cmd == 8'd0) ? 2'b00 : 2'b01; // first board drives the clock
						com_data     <= cmd + 8'd1; // next board gets the next id
						new_com_data <= 1'b1;
					end else if (cmd >= CMD_LASTBASE && cmd < CMD_LASTBASE + CMD_RANGE) begin
						imthelast    <= ((cmd - CMD_LASTBASE) == board_id);
						com_data     <= cmd;
						new_com_data <= 1'b1;
					end else if (cmd >= CMD_ACTBASE && cmd < CMD_ACTBASE + CMD_RANGE) begin
						if ((cmd - CMD_ACTBASE) == board_id) begin
							serial_passthrough <= 1'b0; // selected, the chain stops here
						end else begin
							serial_passthrough <= 1'b1;
							com_data           <= cmd;
							new_com_data       <= 1'b1;
						end
					end else if (arg_cnt < arg_need) begin
						com_data     <= cmd; // forward now, arguments follow
						new_com_data <= 1'b1;
						state        <= DEC_MORE;
					end else begin
						case (cmd)
							CMD_ROLL_ON, CMD_ROLL_OFF: begin
								trig_cfg.rolling <= (cmd == CMD_ROLL_ON);
								com_data         <= cmd;
								new_com_data     <= 1'b1;
							end
							CMD_THRESH:  trig_cfg.thresh    <= arg_buf[0];
							CMD_THRESH2: trig_cfg.thresh2   <= arg_buf[0];
							CMD_TYPE:    trig_cfg.trig_type <= arg_buf[0][3:0];
							CMD_GAIN, CMD_OVERSAMP: begin
								gain_sel      <= (cmd == CMD_GAIN) ? gain_nxt : gain_sel;
								oversamp      <= (cmd == CMD_OVERSAMP) ? ovs_nxt : oversamp;
								// expander port a is {oversampling, gain}, written even if unchanged
								i2c_req       <= '{addr: EXP_GAIN_ADDR, count: 2'd2, data0: EXP_PORTA,
									data1: (cmd == CMD_GAIN) ? {oversamp, gain_nxt} : {ovs_nxt, gain_sel},
									data2: 8'h00};
								i2c_req_valid <= 1'b1;
								state         <= DEC_I2C_WAIT;
							end
							CMD_I2C_RAW: begin
								i2c_req       <= '{addr: arg_buf[1][6:0], count: arg_buf[0][1:0],
									data0: arg_buf[2], data1: arg_buf[3], data2: arg_buf[4]};
								i2c_req_valid <= 1'b1;
								state         <= DEC_I2C_WAIT;
							end
							CMD_TDC_DELAY, CMD_TDC_CARRY, CMD_CHIPID: begin
								if (serial_passthrough) begin
									com_data     <= cmd; // the active board is further down
									new_com_data <= 1'b1;
								end else begin
									if (cmd == CMD_CHIPID)
										reply <= '{len: 4'd8, payload: chip_id};
									else if (cmd == CMD_TDC_DELAY)
										reply <= '{len: 4'd1, payload: {56'd0, delay_count}};
									else
										reply <= '{len: 4'd1, payload: {56'd0, carry_count}};
									reply_go <= 1'b1;
									state    <= DEC_REPLY_WAIT;
								end
							end
							default: begin
								com_data     <= cmd; // unknown here, maybe not downstream
								new_com_data <= 1'b1;
							end
						endcase
					end
				end
				DEC_REPLY_WAIT: if (reply_done) state <= DEC_IDLE;
				DEC_I2C_WAIT: begin
					if (i2c_gnt) begin
						i2c_req_valid <= 1'b0;
						state         <= DEC_IDLE;
					end
				end
				default: state <= DEC_IDLE;
			endcase
		end
	end

endmodule

/* design/i2c_arbiter.sv */
// two-requester arbiter for the one i2c sequencer; decoder always wins, no fairness toward the indicator
`timescale 1ns/100ps

module i2c_arbiter (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                cmd_valid,
	input  scope_pkg::i2c_req_t cmd_req,
	input  logic                led_valid,
	input  scope_pkg::i2c_req_t led_req,
	input  logic                seq_done,
	output logic                cmd_gnt,
	output logic                led_gnt,
	output logic                seq_go,
	output scope_pkg::i2c_req_t seq_req
);

	logic busy; // a transfer is running on the sequencer

	// grant pulses in the cycle the request is taken
	assign cmd_gnt = !busy && cmd_valid;
	assign led_gnt = !busy && !cmd_valid && led_valid;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy   <= 1'b0;
			seq_go <= 1'b0;
		end else begin
			seq_go <= cmd_gnt || led_gnt;
			if (cmd_gnt || led_gnt)
				busy <= 1'b1;
			else if (seq_done)
				busy <= 1'b0; // free for the next owner
		end
	end

	// copy of the granted request, held for the sequencer
	always_ff @(posedge clk) begin
		if (cmd_gnt)
			seq_req <= cmd_req;
		else if (led_gnt)
			seq_req <= led_req;
	end

endmodule

/* design/i2c_sequencer.sv */
// writes 1 to 3 bytes through an eewiki style byte master; write only, ack errors are not checked
`timescale 1ns/100ps

module i2c_sequencer (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  seq_go,
	input  scope_pkg::i2c_req_t   seq_req,
	input  logic                  i2c_busy,
	output logic                  i2c_ena,
	output scope_pkg::i2c_addr_t  i2c_addr,
	output logic                  i2c_rw,
	output scope_pkg::byte_t      i2c_datawr,
	output logic                  seq_done
);
	import scope_pkg::*;

	seq_state_e state;
	i2c_req_t   cur;  // request being written
	logic [1:0] idx;  // data bytes started so far

	assign i2c_rw = 1'b0; // only writes are issued

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= SEQ_IDLE;
			i2c_ena  <= 1'b0;
			idx      <= 2'd0;
			seq_done <= 1'b0;
		end else begin
			seq_done <= 1'b0;
			case (state)
				SEQ_IDLE: begin
					if (seq_go) begin
						cur   <= seq_req;
						state <= SEQ_WAIT_FREE;
					end
				end
				SEQ_WAIT_FREE: begin
					if (!i2c_busy) begin
						i2c_addr   <= cur.addr;
						i2c_datawr <= cur.data0;
						i2c_ena    <= 1'b1;
						idx        <= 2'd1;
						state      <= SEQ_SEND;
					end
				end
				SEQ_SEND: begin
					if (i2c_busy) begin // master latched the current byte
						if (idx >= cur.count) begin
							i2c_ena <= 1'b0; // last byte started, stop after it
						end else begin
							i2c_datawr <= (idx == 2'd1) ? cur.data1 : cur.data2;
							idx        <= idx + 2'd1;
						end
						state <= SEQ_HOLD;
					end
				end
				SEQ_HOLD: begin
					if (!i2c_busy) begin // byte finished
						if (i2c_ena) begin
							state <= SEQ_SEND; // more to go, wait for the next start
						end else begin
							seq_done <= 1'b1;
							state    <= SEQ_IDLE;
						end
					end
				end
				default: state <= SEQ_IDLE;
			endcase
		end
	end

endmodule

/* design/id_indicator.sv */
// shows the board id on four leds of the second expander; only ids 0 to 4 get a distinct pattern
`timescale 1ns/100ps

module id_indicator (
	input  logic                 clk,
	input  logic                 rst_n,
	input  scope_pkg::board_id_t board_id,
	input  logic                 last_board,
	input  logic                 gnt,
	output logic                 req_valid,
	output scope_pkg::i2c_req_t  req
);
	import scope_pkg::*;

	led_t pattern;   // wanted led state
	led_t last_pat;  // pattern last put into a request

	always_comb begin
		if (last_board)
			pattern = 4'b1111; // end of chain lights everything
		else if (board_id == 8'd0)
			pattern = 4'b0000;
		else if (board_id <= 8'd4)
			pattern = board_id[3:0]; // binary id
		else
			pattern = 4'b1111; // unassigned or out of range
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			req_valid <= 1'b0;
			last_pat  <= LED_RESET;
		end else if (pattern != last_pat) begin
			// new or refreshed request, a pending one just gets the newer data
			last_pat  <= pattern;
			req_valid <= 1'b1;
			req       <= '{addr: EXP_LED_ADDR, count: 2'd2, data0: EXP_PORTA,
				data1: {4'b1111, pattern}, data2: 8'h00};
		end else if (gnt) begin
			req_valid <= 1'b0;
		end
	end

endmodule

/* design/reply_sender.sv */
// sends 1 to 8 reply bytes, lsb byte first; relies on tx_busy rising after every tx_start
`timescale 1ns/100ps

module reply_sender (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              reply_go,
	input  scope_pkg::reply_t reply,
	input  logic              tx_busy,
	output logic              tx_start,
	output scope_pkg::byte_t  tx_data,
	output logic              reply_done
);

	logic [63:0] payload;    // shifts right one byte per send
	logic [3:0]  bytes_left;
	logic        active;
	logic        in_flight;  // byte handed to the transmitter
	logic        seen_busy;  // transmitter has taken it

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			active     <= 1'b0;
			in_flight  <= 1'b0;
			seen_busy  <= 1'b0;
			bytes_left <= 4'd0;
			tx_start   <= 1'b0;
			reply_done <= 1'b0;
		end else begin
			tx_start   <= 1'b0;
			reply_done <= 1'b0;
			if (reply_go) begin
				payload    <= reply.payload;
				bytes_left <= reply.len;
				active     <= 1'b1;
				in_flight  <= 1'b0;
			end else if (active) begin
				if (!in_flight) begin
					if (!tx_busy) begin // transmitter free, start next byte
						tx_data    <= payload[7:0];
						tx_start   <= 1'b1;
						payload    <= payload >> 8;
						bytes_left <= bytes_left - 4'd1;
						in_flight  <= 1'b1;
						seen_busy  <= 1'b0;
					end
				end else if (!seen_busy) begin
					if (tx_busy) seen_busy <= 1'b1;
				end else if (!tx_busy) begin // byte is out
					in_flight <= 1'b0;
					if (bytes_left == 4'd0) begin
						active     <= 1'b0;
						reply_done <= 1'b1;
					end
				end
			end
		end
	end

endmodule

/* design/scope_pkg.sv */
// shared types and constants of the board controller; command codes follow the chain protocol, ids above 9 are never assigned
package scope_pkg;

	typedef logic [7:0] byte_t;      // serial or i2c data byte
	typedef logic [7:0] board_id_t;  // position of the board in the chain
	typedef logic [3:0] chan_mask_t; // one bit per analog channel
	typedef logic [3:0] led_t;       // id indicator leds, 1 = lit
	typedef logic [6:0] i2c_addr_t;  // 7 bit slave address

	// one i2c write as handed to the sequencer
	typedef struct packed {
		i2c_addr_t  addr;
		logic [1:0] count; // data bytes to write, 1 to 3
		byte_t      data0;
		byte_t      data1;
		byte_t      data2;
	} i2c_req_t;

	typedef struct packed {
		byte_t      thresh;    // normal trigger threshold
		byte_t      thresh2;   // high threshold, must be below to trigger
		logic [3:0] trig_type; // bit 0 rising edge
		logic       rolling;
	} trig_cfg_t;

	typedef struct packed {
		logic [3:0]  len;     // bytes to send, 1 to 8
		logic [63:0] payload; // byte 0 goes out first
	} reply_t;

	typedef enum logic [2:0] {
		DEC_IDLE,
		DEC_SOLVE,
		DEC_MORE,
		DEC_REPLY_WAIT,
		DEC_I2C_WAIT
	} dec_state_e;

	typedef enum logic [1:0] {
		SEQ_IDLE,
		SEQ_WAIT_FREE,
		SEQ_SEND,
		SEQ_HOLD
	} seq_state_e;

	localparam byte_t CMD_ID_LAST   = 8'd9;
	localparam byte_t CMD_LASTBASE  = 8'd20;
	localparam byte_t CMD_ACTBASE   = 8'd30;
	localparam byte_t CMD_RANGE     = 8'd10; // width of the id based groups
	localparam byte_t CMD_ROLL_ON   = 8'd101;
	localparam byte_t CMD_ROLL_OFF  = 8'd102;
	localparam byte_t CMD_THRESH    = 8'd127;
	localparam byte_t CMD_TYPE      = 8'd128;
	localparam byte_t CMD_TDC_DELAY = 8'd132;
	localparam byte_t CMD_TDC_CARRY = 8'd133;
	localparam byte_t CMD_GAIN      = 8'd134;
	localparam byte_t CMD_I2C_RAW   = 8'd136;
	localparam byte_t CMD_THRESH2   = 8'd140;
	localparam byte_t CMD_OVERSAMP  = 8'd141;
	localparam byte_t CMD_CHIPID    = 8'd142;

	localparam i2c_addr_t EXP_GAIN_ADDR = 7'h20; // front-end expander
	localparam i2c_addr_t EXP_LED_ADDR  = 7'h21; // indicator expander
	localparam byte_t     EXP_PORTA     = 8'h12; // gpio register of port a

	localparam board_id_t  BOARD_ID_RESET = 8'd200; // not yet in a chain
	localparam chan_mask_t GAIN_RESET     = 4'b0000; // low gain on all channels
	localparam chan_mask_t OVERSAMP_RESET = 4'b0011; // 1 means no oversampling
	localparam led_t       LED_RESET      = 4'b1111; // pattern of the reset id
	localparam trig_cfg_t  TRIG_RESET     = '{
		thresh:    8'h80,
		thresh2:   8'hFF,
		trig_type: 4'b0001,
		rolling:   1'b1
	};

endpackage

/* run_sim.sh */
#!/bin/bash
# build and run the board controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module board_ctrl_tb \
	-f board_ctrl.f -o sim_board_ctrl > build.log 2>&1 \
	|| { echo "build failed, see build.log"; exit 1; }

./obj_dir/sim_board_ctrl > sim.log 2>&1
cat sim.log

grep -q "ALL TESTS PASSED" sim.log && echo "PASS" && exit 0 || { echo "FAIL"; exit 1; }
